//--- source/soc_bus_pkg.sv
package soc_bus_pkg;

	//============================================================
	// Bus word types

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// Top address nibble selects the region
	typedef logic [3:0] region_t;

	// Address bits 27 down to 2
	typedef logic [25:0] word_index_t;

	// Bus owner, same codes as the fault type
	typedef enum logic [1:0] {
		REQ_NONE = 2'd0,
		REQ_IBUS = 2'd1,
		REQ_DBUS = 2'd2,
		REQ_DMA  = 2'd3
	} requester_e;

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_e;

	//============================================================
	// Memory map

	localparam region_t REGION_RAM   = 4'h1;
	localparam region_t REGION_SDRAM = 4'h2;

	localparam int WORD_LSB = 2;

	localparam int RAM_WORDS     = 512;
	localparam int SDRAM_WORDS   = 4096;
	localparam int RAM_LATENCY   = 1;
	localparam int SDRAM_LATENCY = 16;

endpackage

//--- source/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter import soc_bus_pkg::*; (
	input  logic       i_clock,
	input  logic       i_arst_n,

	// Instruction port, read only
	input  logic       i_ibus_request,
	input  addr_t      i_ibus_address,
	output logic       o_ibus_ready,
	output data_t      o_ibus_rdata,

	// Data port
	input  logic       i_dbus_request,
	input  logic       i_dbus_rw,
	input  addr_t      i_dbus_address,
	input  data_t      i_dbus_wdata,
	output logic       o_dbus_ready,
	output data_t      o_dbus_rdata,

	// DMA port
	input  logic       i_dma_request,
	input  logic       i_dma_rw,
	input  addr_t      i_dma_address,
	input  data_t      i_dma_wdata,
	output logic       o_dma_ready,
	output data_t      o_dma_rdata,

	// Shared bus
	output logic       o_bus_request,
	output logic       o_bus_rw,
	output addr_t      o_bus_address,
	output data_t      o_bus_wdata,
	output requester_e o_bus_owner,
	input  logic       i_bus_ready,
	input  data_t      i_bus_rdata
);

	arb_state_e state;
	requester_e grant;
	logic       done;

	// Fixed priority, instruction fetch first
	always_comb begin
		if (i_ibus_request)
			grant = REQ_IBUS;
		else if (i_dbus_request)
			grant = REQ_DBUS;
		else if (i_dma_request)
			grant = REQ_DMA;
		else
			grant = REQ_NONE;
	end

	assign done = (state == ARB_BUSY) && i_bus_ready;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state         <= ARB_IDLE;
			o_bus_request <= 1'b0;
			o_bus_owner   <= REQ_NONE;
		end else if (state == ARB_IDLE) begin
			if (grant != REQ_NONE) begin
				state         <= ARB_BUSY;
				o_bus_request <= 1'b1;
				o_bus_owner   <= grant;
			end
		end else if (i_bus_ready) begin
			state         <= ARB_IDLE;
			o_bus_request <= 1'b0;
			o_bus_owner   <= REQ_NONE;
		end
	end

	// Winner's fields latched onto the bus at grant
	always_ff @(posedge i_clock) begin
		if (state == ARB_IDLE) begin
			case (grant)
				REQ_IBUS: begin
					o_bus_rw      <= 1'b0;
					o_bus_address <= i_ibus_address;
					o_bus_wdata   <= '0;
				end
				REQ_DBUS: begin
					o_bus_rw      <= i_dbus_rw;
					o_bus_address <= i_dbus_address;
					o_bus_wdata   <= i_dbus_wdata;
				end
				REQ_DMA: begin
					o_bus_rw      <= i_dma_rw;
					o_bus_address <= i_dma_address;
					o_bus_wdata   <= i_dma_wdata;
				end
				default: ;
			endcase
		end
	end

	// Return path goes to the owner only
	assign o_ibus_ready = done && (o_bus_owner == REQ_IBUS);
	assign o_dbus_ready = done && (o_bus_owner == REQ_DBUS);
	assign o_dma_ready  = done && (o_bus_owner == REQ_DMA);

	assign o_ibus_rdata = (o_bus_owner == REQ_IBUS) ? i_bus_rdata : '0;
	assign o_dbus_rdata = (o_bus_owner == REQ_DBUS) ? i_bus_rdata : '0;
	assign o_dma_rdata  = (o_bus_owner == REQ_DMA) ? i_bus_rdata : '0;

endmodule

//--- source/bus_addr_decode.sv
`timescale 1ns/1ns

module bus_addr_decode import soc_bus_pkg::*; (
	input  logic        i_bus_request,
	input  addr_t       i_bus_address,
	output logic        o_ram_request,
	output logic        o_sdram_request,
	output logic        o_unmapped_request,
	output word_index_t o_word_index
);

	region_t region;
	logic    ram_hit;
	logic    sdram_hit;

	// Region from the top nibble, word index from the rest
	assign region       = i_bus_address[31 -: $bits(region_t)];
	assign o_word_index = i_bus_address[WORD_LSB +: $bits(word_index_t)];

	assign ram_hit   = (region == REGION_RAM);
	assign sdram_hit = (region == REGION_SDRAM);

	assign o_ram_request      = i_bus_request && ram_hit;
	assign o_sdram_request    = i_bus_request && sdram_hit;

	// Everything else has no slave behind it
	assign o_unmapped_request = i_bus_request && !ram_hit && !sdram_hit;

endmodule

//--- source/latency_ram.sv
`timescale 1ns/1ns

module latency_ram import soc_bus_pkg::*; #(
	parameter int WORDS   = RAM_WORDS,
	parameter int LATENCY = RAM_LATENCY
) (
	input  logic        i_clock,
	input  logic        i_arst_n,
	input  logic        i_request,
	input  logic        i_rw,
	input  word_index_t i_word_index,
	input  data_t       i_wdata,
	output data_t       o_rdata,
	output logic        o_ready
);

	localparam int SLOT_BITS  = $clog2(WORDS);
	localparam int COUNT_BITS = $clog2(LATENCY + 1);

	data_t                 mem [WORDS];
	logic [SLOT_BITS-1:0]  slot;
	logic [COUNT_BITS-1:0] remaining;
	logic                  busy;
	logic                  start;

	// Index wraps around the memory size
	assign slot  = SLOT_BITS'(i_word_index % WORDS);
	assign start = i_request && !busy;

	// Ready in the LATENCY-th cycle after the start cycle
	assign o_ready = busy && (remaining == COUNT_BITS'(1));

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy      <= 1'b0;
			remaining <= '0;
		end else if (start) begin
			busy      <= 1'b1;
			remaining <= COUNT_BITS'(LATENCY);
		end else if (busy) begin
			remaining <= remaining - 1'b1;
			if (o_ready)
				busy <= 1'b0;
		end
	end

	// Write lands at the start, read word held until ready
	always_ff @(posedge i_clock) begin
		if (start) begin
			if (i_rw)
				mem[slot] <= i_wdata;
			o_rdata <= mem[slot];
		end
	end

endmodule

//--- source/bus_response.sv
`timescale 1ns/1ns

module bus_response import soc_bus_pkg::*; (
	input  logic       i_clock,
	input  logic       i_arst_n,
	input  logic       i_ram_ready,
	input  data_t      i_ram_rdata,
	input  logic       i_sdram_ready,
	input  data_t      i_sdram_rdata,
	input  logic       i_unmapped_request,
	input  addr_t      i_bus_address,
	input  requester_e i_bus_owner,
	output logic       o_bus_ready,
	output data_t      o_bus_rdata,
	output logic       o_bus_fault,
	output addr_t      o_fault_address,
	output requester_e o_fault_source
);

	logic unmapped_ready;
	logic answered;
	logic unmapped_first;

	// First cycle of an unmapped access
	assign unmapped_first = i_unmapped_request && !unmapped_ready && !answered;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			unmapped_ready <= 1'b0;
			answered       <= 1'b0;
		end else begin
			unmapped_ready <= unmapped_first;
			// Stays set while the same request is still on the bus
			answered       <= i_unmapped_request && (answered || unmapped_ready);
		end
	end

	//============================================================
	// Sticky fault record

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_bus_fault     <= 1'b0;
			o_fault_address <= '0;
			o_fault_source  <= REQ_NONE;
		end else if (unmapped_first) begin
			o_bus_fault     <= 1'b1;
			o_fault_address <= i_bus_address;
			o_fault_source  <= i_bus_owner;
		end
	end

	//============================================================
	// Merged return

	assign o_bus_ready = i_ram_ready | i_sdram_ready | unmapped_ready;

	// Unmapped reads come back as zero
	assign o_bus_rdata =
		i_ram_ready   ? i_ram_rdata   :
		i_sdram_ready ? i_sdram_rdata :
		'0;

endmodule

//--- source/soc_bus_top.sv
`timescale 1ns/1ns

module soc_bus_top import soc_bus_pkg::*; (
	input  logic       i_clock,
	input  logic       i_arst_n,

	input  logic       i_ibus_request,
	input  addr_t      i_ibus_address,
	output logic       o_ibus_ready,
	output data_t      o_ibus_rdata,

	input  logic       i_dbus_request,
	input  logic       i_dbus_rw,
	input  addr_t      i_dbus_address,
	input  data_t      i_dbus_wdata,
	output logic       o_dbus_ready,
	output data_t      o_dbus_rdata,

	input  logic       i_dma_request,
	input  logic       i_dma_rw,
	input  addr_t      i_dma_address,
	input  data_t      i_dma_wdata,
	output logic       o_dma_ready,
	output data_t      o_dma_rdata,

	output logic       o_bus_fault,
	output addr_t      o_fault_address,
	output requester_e o_fault_source
);

	// Single registered bus
	logic        bus_request;
	logic        bus_rw;
	addr_t       bus_address;
	data_t       bus_wdata;
	requester_e  bus_owner;
	logic        bus_ready;
	data_t       bus_rdata;

	// Decoded per region
	logic        ram_request;
	logic        sdram_request;
	logic        unmapped_request;
	word_index_t word_index;

	logic        ram_ready;
	data_t       ram_rdata;
	logic        sdram_ready;
	data_t       sdram_rdata;

	bus_arbiter u_arbiter (
		.i_clock        (i_clock),
		.i_arst_n       (i_arst_n),
		.i_ibus_request (i_ibus_request),
		.i_ibus_address (i_ibus_address),
		.o_ibus_ready   (o_ibus_ready),
		.o_ibus_rdata   (o_ibus_rdata),
		.i_dbus_request (i_dbus_request),
		.i_dbus_rw      (i_dbus_rw),
		.i_dbus_address (i_dbus_address),
		.i_dbus_wdata   (i_dbus_wdata),
		.o_dbus_ready   (o_dbus_ready),
		.o_dbus_rdata   (o_dbus_rdata),
		.i_dma_request  (i_dma_request),
		.i_dma_rw       (i_dma_rw),
		.i_dma_address  (i_dma_address),
		.i_dma_wdata    (i_dma_wdata),
		.o_dma_ready    (o_dma_ready),
		.o_dma_rdata    (o_dma_rdata),
		.o_bus_request  (bus_request),
		.o_bus_rw       (bus_rw),
		.o_bus_address  (bus_address),
		.o_bus_wdata    (bus_wdata),
		.o_bus_owner    (bus_owner),
		.i_bus_ready    (bus_ready),
		.i_bus_rdata    (bus_rdata)
	);

	bus_addr_decode u_decode (
		.i_bus_request      (bus_request),
		.i_bus_address      (bus_address),
		.o_ram_request      (ram_request),
		.o_sdram_request    (sdram_request),
		.o_unmapped_request (unmapped_request),
		.o_word_index       (word_index)
	);

	//============================================================
	// Memories

	latency_ram #(
		.WORDS   (RAM_WORDS),
		.LATENCY (RAM_LATENCY)
	) u_ram (
		.i_clock      (i_clock),
		.i_arst_n     (i_arst_n),
		.i_request    (ram_request),
		.i_rw         (bus_rw),
		.i_word_index (word_index),
		.i_wdata      (bus_wdata),
		.o_rdata      (ram_rdata),
		.o_ready      (ram_ready)
	);

	latency_ram #(
		.WORDS   (SDRAM_WORDS),
		.LATENCY (SDRAM_LATENCY)
	) u_sdram (
		.i_clock      (i_clock),
		.i_arst_n     (i_arst_n),
		.i_request    (sdram_request),
		.i_rw         (bus_rw),
		.i_word_index (word_index),
		.i_wdata      (bus_wdata),
		.o_rdata      (sdram_rdata),
		.o_ready      (sdram_ready)
	);

	bus_response u_response (
		.i_clock            (i_clock),
		.i_arst_n           (i_arst_n),
		.i_ram_ready        (ram_ready),
		.i_ram_rdata        (ram_rdata),
		.i_sdram_ready      (sdram_ready),
		.i_sdram_rdata      (sdram_rdata),
		.i_unmapped_request (unmapped_request),
		.i_bus_address      (bus_address),
		.i_bus_owner        (bus_owner),
		.o_bus_ready        (bus_ready),
		.o_bus_rdata        (bus_rdata),
		.o_bus_fault        (o_bus_fault),
		.o_fault_address    (o_fault_address),
		.o_fault_source     (o_fault_source)
	);

endmodule

//--- sim/tb_soc_bus.sv
`timescale 1ns/1ns

module tb_soc_bus import soc_bus_pkg::*; ();

	localparam int TRANSACTIONS      = 300;
	localparam int WORD_RANGE        = 16;
	localparam int PRELOAD_TRANSFERS = 2 * WORD_RANGE;
	localparam int TIMEOUT_CYCLES    = (TRANSACTIONS * 3 + PRELOAD_TRANSFERS + 16) * 20;
	localparam int RAM_BITS          = $clog2(RAM_WORDS);
	localparam int SDRAM_BITS        = $clog2(SDRAM_WORDS);

	logic       i_clock;
	logic       i_arst_n;
	logic       i_ibus_request;
	addr_t      i_ibus_address;
	logic       o_ibus_ready;
	data_t      o_ibus_rdata;
	logic       i_dbus_request;
	logic       i_dbus_rw;
	addr_t      i_dbus_address;
	data_t      i_dbus_wdata;
	logic       o_dbus_ready;
	data_t      o_dbus_rdata;
	logic       i_dma_request;
	logic       i_dma_rw;
	addr_t      i_dma_address;
	data_t      i_dma_wdata;
	logic       o_dma_ready;
	data_t      o_dma_rdata;
	logic       o_bus_fault;
	addr_t      o_fault_address;
	requester_e o_fault_source;

	// Reference contents of both memories
	data_t ram_model [RAM_WORDS];
	data_t sdram_model [SDRAM_WORDS];

	int   cycle;
	int   checks;
	int   value_errors;
	int   other_errors;
	int   ready_at [4];
	logic fault_seen;

	soc_bus_top i_dut (
		.i_clock         (i_clock),
		.i_arst_n        (i_arst_n),
		.i_ibus_request  (i_ibus_request),
		.i_ibus_address  (i_ibus_address),
		.o_ibus_ready    (o_ibus_ready),
		.o_ibus_rdata    (o_ibus_rdata),
		.i_dbus_request  (i_dbus_request),
		.i_dbus_rw       (i_dbus_rw),
		.i_dbus_address  (i_dbus_address),
		.i_dbus_wdata    (i_dbus_wdata),
		.o_dbus_ready    (o_dbus_ready),
		.o_dbus_rdata    (o_dbus_rdata),
		.i_dma_request   (i_dma_request),
		.i_dma_rw        (i_dma_rw),
		.i_dma_address   (i_dma_address),
		.i_dma_wdata     (i_dma_wdata),
		.o_dma_ready     (o_dma_ready),
		.o_dma_rdata     (o_dma_rdata),
		.o_bus_fault     (o_bus_fault),
		.o_fault_address (o_fault_address),
		.o_fault_source  (o_fault_source)
	);

	always #10 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		cycle = cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//============================================================
	// Checks and model

	task automatic check_value(input string name, input data_t expected, input data_t actual);
		checks++;
		assert (actual === expected) else begin
			value_errors++;
			$display("ERR %s expected %08h actual %08h", name, expected, actual);
		end
	endtask

	task automatic check_state(input logic ok, input string what);
		checks++;
		assert (ok === 1'b1) else begin
			other_errors++;
			$display("Check failed: %s", what);
		end
	endtask

	function automatic logic is_mapped(addr_t addr);
		return (addr[31:28] == REGION_RAM) || (addr[31:28] == REGION_SDRAM);
	endfunction

	// Word index wraps modulo the memory size
	function automatic data_t model_read(addr_t addr);
		word_index_t idx;
		idx = addr[27:2];
		if (addr[31:28] == REGION_RAM)
			return ram_model[RAM_BITS'(idx % RAM_WORDS)];
		if (addr[31:28] == REGION_SDRAM)
			return sdram_model[SDRAM_BITS'(idx % SDRAM_WORDS)];
		return '0;
	endfunction

	function automatic void model_write(addr_t addr, data_t data);
		word_index_t idx;
		idx = addr[27:2];
		if (addr[31:28] == REGION_RAM)
			ram_model[RAM_BITS'(idx % RAM_WORDS)] = data;
		else if (addr[31:28] == REGION_SDRAM)
			sdram_model[SDRAM_BITS'(idx % SDRAM_WORDS)] = data;
	endfunction

	function automatic addr_t region_address(region_t region, int index);
		return {region, word_index_t'(index), 2'b00};
	endfunction

	// Small word range with aliases and now and then an unmapped region
	function automatic addr_t random_address();
		region_t region;
		int      index;
		index = int'($urandom % WORD_RANGE);
		if ($urandom % 20 == 0)
			region = region_t'(3 + $urandom % 13);
		else if ($urandom % 2 == 0) begin
			region = REGION_RAM;
			index  = index + int'($urandom % 4) * RAM_WORDS;
		end else begin
			region = REGION_SDRAM;
			index  = index + int'($urandom % 4) * SDRAM_WORDS;
		end
		return region_address(region, index);
	endfunction

	//============================================================
	// Master ports

	function automatic logic port_ready(requester_e port);
		case (port)
			REQ_IBUS: return o_ibus_ready;
			REQ_DBUS: return o_dbus_ready;
			REQ_DMA:  return o_dma_ready;
			default:  return 1'b0;
		endcase
	endfunction

	function automatic data_t port_rdata(requester_e port);
		case (port)
			REQ_IBUS: return o_ibus_rdata;
			REQ_DBUS: return o_dbus_rdata;
			REQ_DMA:  return o_dma_rdata;
			default:  return '0;
		endcase
	endfunction

	task automatic drive_port(input requester_e port, input logic req, input logic rw,
			input addr_t addr, input data_t wdata);
		case (port)
			REQ_IBUS: begin
				i_ibus_request = req;
				i_ibus_address = addr;
			end
			REQ_DBUS: begin
				i_dbus_request = req;
				i_dbus_rw      = rw;
				i_dbus_address = addr;
				i_dbus_wdata   = wdata;
			end
			REQ_DMA: begin
				i_dma_request = req;
				i_dma_rw      = rw;
				i_dma_address = addr;
				i_dma_wdata   = wdata;
			end
			default: ;
		endcase
	endtask

	// One transaction from a falling edge up to its ready edge
	task automatic transfer(input requester_e port, input logic rw, input addr_t addr,
			input data_t wdata, input string name);
		logic  ready;
		data_t rdata;
		ready = 1'b0;
		rdata = '0;
		drive_port(port, 1'b1, rw, addr, wdata);
		while (!ready) begin
			@(negedge i_clock);
			ready = port_ready(port);
			rdata = port_rdata(port);
		end
		ready_at[port] = cycle;
		drive_port(port, 1'b0, 1'b0, '0, '0);
		if (!is_mapped(addr)) begin
			check_value({name, " unmapped rdata"}, '0, rdata);
			check_state(o_bus_fault, "fault flag not set by an unmapped access");
			check_value({name, " fault address"}, addr, o_fault_address);
			check_value({name, " fault source"}, data_t'(port), data_t'(o_fault_source));
			fault_seen = 1'b1;
		end else begin
			if (rw)
				model_write(addr, wdata);
			else
				check_value(name, model_read(addr), rdata);
			if (fault_seen)
				check_state(o_bus_fault, "fault flag dropped without a reset");
			else
				check_state(!o_bus_fault, "fault flag set by a mapped access");
		end
	endtask

	task automatic run_random(input requester_e port, input string name);
		logic rw;
		for (int n = 0; n < TRANSACTIONS; n++) begin
			rw = (port == REQ_IBUS) ? 1'b0 : 1'($urandom % 2);
			transfer(port, rw, random_address(), $urandom, name);
			repeat ($urandom % 3) @(negedge i_clock);
		end
	endtask

	//============================================================
	// Test sequence

	initial begin
		void'($urandom(63965));
		i_clock        = 1'b0;
		i_arst_n       = 1'b0;
		i_ibus_request = 1'b0;
		i_ibus_address = '0;
		i_dbus_request = 1'b0;
		i_dbus_rw      = 1'b0;
		i_dbus_address = '0;
		i_dbus_wdata   = '0;
		i_dma_request  = 1'b0;
		i_dma_rw       = 1'b0;
		i_dma_address  = '0;
		i_dma_wdata    = '0;
		cycle          = 0;
		checks         = 0;
		value_errors   = 0;
		other_errors   = 0;
		fault_seen     = 1'b0;
		repeat (3) @(posedge i_clock);
		@(negedge i_clock);
		i_arst_n = 1'b1;

		// Quiet bus after reset
		repeat (4) begin
			@(negedge i_clock);
			check_state(!(o_ibus_ready || o_dbus_ready || o_dma_ready),
				"a port ready rose with no request");
			check_state(!o_bus_fault, "fault flag set after reset");
		end

		// Fill the word range so that every read has known data
		for (int i = 0; i < WORD_RANGE; i++) begin
			transfer(REQ_DBUS, 1'b1, region_address(REGION_RAM, i), $urandom, "preload ram");
			transfer(REQ_DBUS, 1'b1, region_address(REGION_SDRAM, i), $urandom, "preload sdram");
		end

		transfer(REQ_DBUS, 1'b1, region_address(REGION_RAM, 5), 32'hcafe_0005, "dbus write");
		transfer(REQ_DBUS, 1'b0, region_address(REGION_RAM, 5), '0, "dbus read");
		transfer(REQ_DBUS, 1'b0, region_address(REGION_RAM, 5 + 2 * RAM_WORDS), '0, "ram alias");
		transfer(REQ_DBUS, 1'b1, region_address(REGION_SDRAM, 7), 32'h5d7a_0007, "dbus sdram");
		transfer(REQ_DMA, 1'b0, region_address(REGION_SDRAM, 7), '0, "dma sdram read");
		transfer(REQ_DMA, 1'b1, region_address(REGION_SDRAM, 9), 32'hd0a0_0009, "dma write");
		transfer(REQ_IBUS, 1'b0, region_address(REGION_SDRAM, 9), '0, "ibus read");
		transfer(REQ_IBUS, 1'b0, region_address(REGION_RAM, 5), '0, "ibus ram read");

		// Unmapped access followed by good accesses that keep the flag set
		transfer(REQ_DBUS, 1'b1, 32'h3000_0040, 32'h1234_5678, "unmapped write");
		transfer(REQ_DMA, 1'b0, region_address(REGION_RAM, 3), '0, "read after fault");

		// All three ports at once on an idle bus
		@(negedge i_clock);
		fork
			transfer(REQ_IBUS, 1'b0, region_address(REGION_SDRAM, 2), '0, "race ibus");
			transfer(REQ_DBUS, 1'b0, region_address(REGION_RAM, 4), '0, "race dbus");
			transfer(REQ_DMA, 1'b0, region_address(REGION_SDRAM, 6), '0, "race dma");
		join
		check_state(ready_at[REQ_IBUS] < ready_at[REQ_DBUS], "dbus finished before ibus");
		check_state(ready_at[REQ_DBUS] < ready_at[REQ_DMA], "dma finished before dbus");

		fork
			run_random(REQ_IBUS, "random ibus");
			run_random(REQ_DBUS, "random dbus");
			run_random(REQ_DMA, "random dma");
		join

		@(negedge i_clock);
		i_arst_n = 1'b0;
		@(negedge i_clock);
		check_state(!o_bus_fault, "fault flag not cleared by reset");
		i_arst_n = 1'b1;
		@(negedge i_clock);

		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- list.f
source/soc_bus_pkg.sv
source/bus_arbiter.sv
source/bus_addr_decode.sv
source/latency_ram.sv
source/bus_response.sv
source/soc_bus_top.sv
sim/tb_soc_bus.sv

//--- Makefile
# Verilator simulation of the SoC bus

VERILATOR ?= verilator
TOP       ?= tb_soc_bus
LOG       ?= sim.log
BUILD     ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f list.f --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
